// File: logic/chol_settings.svh
/* Cholesky factor sizes */

`ifndef CHOL_SETTINGS_SVH
`define CHOL_SETTINGS_SVH

// Matrix dimension, one row lane per row
`define CHOL_N 4

// A and the working matrix hold sums of products of two factor entries
`define CHOL_ELEM_W 27

// Entries of L, wide enough for the root of the largest element
`define CHOL_ROOT_W 14

// Row and column index, log2 of CHOL_N
`define CHOL_IDX_W 2

`endif

// File: logic/chol_num_pkg.sv
/* Numeric matrix types */

`include "chol_settings.svh"

package chol_num_pkg;

	typedef logic [`CHOL_ELEM_W-1:0] elem_t; // One element of A or the working copy
	typedef logic [`CHOL_ROOT_W-1:0] root_t; // One entry of L

	// Rows are packed with element 0 in the low bits
	typedef elem_t [`CHOL_N-1:0] elem_row_t; // One row of A
	typedef elem_row_t [`CHOL_N-1:0] elem_mat_t; // Whole of A, indexed [row][col]

	typedef root_t [`CHOL_N-1:0] root_vec_t; // One value of L per row
	typedef root_vec_t [`CHOL_N-1:0] root_mat_t; // Whole of L, indexed [row][col]

endpackage

// File: logic/chol_ctrl_pkg.sv
/* Sequencer control types */

`include "chol_settings.svh"

package chol_ctrl_pkg;

	typedef logic [`CHOL_IDX_W-1:0] col_idx_t; // Column or row number

	typedef enum logic [2:0] {
		IDLE, // Waiting for start
		ROOT, // Pivot root in flight
		DIVIDE, // Lanes dividing the column by the root
		UPDATE, // Rank-one update of the trailing rows
		FINISH, // Done pulse
		FAULT // Error pulse after a zero pivot
	} seq_state_t;

endpackage

// File: logic/pivot_bus_if.sv
/* Pivot and column bus */

`include "chol_settings.svh"

interface pivot_bus_if;
	import chol_num_pkg::*;
	import chol_ctrl_pkg::*;

	col_idx_t col; // Column being eliminated
	logic load; // Copy A into the lanes and clear L
	root_t root; // Root of the current pivot
	logic root_valid; // Root is ready, lanes start dividing
	elem_row_t diag; // Each lane shows its own diagonal element
	root_vec_t quot; // Each lane shows its entry of the current L column
	logic [`CHOL_N-1:0] quot_valid; // Division finished, level per lane
	logic update_go; // Apply the rank-one update this cycle

	modport seq (
		output col, load, root, root_valid, update_go,
		input diag, quot_valid
	);

	// A lane drives only its own slice of diag, quot and quot_valid
	modport lane (
		input col, load, root, root_valid, update_go,
		output diag, quot, quot_valid
	);

	modport collector (
		input col, load, root, root_valid, update_go, quot
	);

endinterface

// File: logic/isqrt_unit.sv
/* Integer square root */

`include "chol_settings.svh"

module isqrt_unit (
	input logic i,
	input logic rst,
	input chol_num_pkg::elem_t radicand,
	input logic go,
	output chol_num_pkg::root_t result,
	output logic done
);
	import chol_num_pkg::*;

	localparam int RAD_W = 2 * `CHOL_ROOT_W; // Radicand padded to whole bit pairs
	localparam int REM_W = `CHOL_ROOT_W + 2;
	localparam int STEP_W = $clog2(`CHOL_ROOT_W);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`CHOL_ROOT_W - 1);

	logic [RAD_W-1:0] rad; // Bit pairs shift out at the top
	logic [REM_W-1:0] rem; // Stays below twice the partial root
	root_t root;
	logic [STEP_W-1:0] step;
	logic running;
	logic [REM_W+1:0] shifted;
	logic [REM_W+1:0] trial;
	logic [REM_W+1:0] diff;
	logic fits;

	assign shifted = {rem, rad[RAD_W-1 -: 2]}; // Bring down the next bit pair
	assign trial = {2'b00, root, 2'b01}; // 4 * root + 1 tests the next root bit as one
	assign fits = shifted >= trial;
	assign diff = shifted - trial;
	assign result = root;

	always_ff @(posedge i) begin
		if (rst) begin
			running <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				running <= 1'b1;
				step <= '0;
			end else if (running) begin
				step <= step + 1'b1;
				if (step == LAST_STEP) begin // One root bit per cycle, MSB first
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (go) begin
			rad <= {{(RAD_W - `CHOL_ELEM_W){1'b0}}, radicand};
			rem <= '0;
			root <= '0;
		end else if (running) begin
			rad <= rad << 2;
			rem <= fits ? diff[REM_W-1:0] : shifted[REM_W-1:0];
			root <= {root[`CHOL_ROOT_W-2:0], fits}; // Floor of the root when finished
		end
	end

	a_root_latency: assert property (@(posedge i) disable iff (rst)
		go |-> ##15 done);

endmodule

// File: logic/row_lane.sv
/* Matrix row lane */

`include "chol_settings.svh"

module row_lane #(
	parameter int ROW = 0
) (
	input logic i,
	input logic rst,
	input chol_num_pkg::elem_row_t a_row,
	pivot_bus_if.lane bus
);
	import chol_num_pkg::*;
	import chol_ctrl_pkg::*;

	localparam int DIV_STEPS = `CHOL_ELEM_W; // One quotient bit per dividend bit
	localparam int STEP_W = $clog2(DIV_STEPS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(DIV_STEPS - 1);
	localparam col_idx_t ROW_IDX = col_idx_t'(ROW);

	elem_row_t work; // Working copy of this row of A
	elem_t qd; // Dividend shifts out at the top, quotient shifts in at the bottom
	root_t dsr;
	root_t rem; // Partial remainder, always below the divisor
	root_t quot; // This row's entry of the current L column
	logic [STEP_W-1:0] step;
	logic div_busy;
	logic valid_q;
	logic div_start;
	logic [`CHOL_ROOT_W:0] shifted;
	logic [`CHOL_ROOT_W:0] diff;
	logic fits;
	logic [2*`CHOL_ROOT_W-1:0] prod [`CHOL_N];

	assign div_start = bus.root_valid && (ROW_IDX > bus.col); // Only rows below the pivot divide
	assign shifted = {rem, qd[`CHOL_ELEM_W-1]};
	assign diff = shifted - {1'b0, dsr};
	assign fits = shifted >= {1'b0, dsr};

	// Update multipliers, L[ROW][col] times L[j][col] for every column
	always_comb begin
		for (int j = 0; j < `CHOL_N; j++) begin
			prod[j] = bus.quot[ROW] * bus.quot[j];
		end
	end

	always_ff @(posedge i) begin
		if (bus.load) begin
			work <= a_row;
		end else if (bus.update_go && (ROW_IDX > bus.col)) begin
			for (int j = 0; j < `CHOL_N; j++) begin
				if ((j > bus.col) && (j <= ROW))
					work[j] <= work[j] - prod[j][`CHOL_ELEM_W-1:0]; // Lower triangle only
			end
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			div_busy <= 1'b0;
			valid_q <= 1'b0;
			step <= '0;
		end else if (bus.load) begin
			div_busy <= 1'b0;
			valid_q <= 1'b0;
		end else if (bus.root_valid) begin
			div_busy <= div_start;
			valid_q <= 1'b0; // Old quotient is stale once a new root arrives
			step <= '0;
		end else if (div_busy) begin
			step <= step + 1'b1;
			if (step == LAST_STEP) begin
				div_busy <= 1'b0;
				valid_q <= 1'b1; // Held until the next root
			end
		end
	end

	always_ff @(posedge i) begin
		if (div_start) begin
			qd <= work[bus.col];
			dsr <= bus.root;
			rem <= '0;
		end else if (div_busy) begin
			qd <= {qd[`CHOL_ELEM_W-2:0], fits};
			rem <= fits ? diff[`CHOL_ROOT_W-1:0] : shifted[`CHOL_ROOT_W-1:0];
		end
		if (bus.root_valid && (ROW_IDX == bus.col))
			quot <= bus.root; // Diagonal entry is the root itself
		else if (div_busy && (step == LAST_STEP))
			quot <= {qd[`CHOL_ROOT_W-2:0], fits}; // Exact quotients fit in a root entry
	end

	assign bus.diag[ROW] = work[ROW];
	assign bus.quot[ROW] = quot;
	assign bus.quot_valid[ROW] = valid_q;

	// The sequencer faults on a zero pivot before any lane divides by it
	a_divisor_nonzero: assert property (@(posedge i) disable iff (rst)
		div_start |-> (bus.root != '0));

endmodule

// File: logic/factor_collector.sv
/* Factor collector */

`include "chol_settings.svh"

module factor_collector (
	input logic i,
	input logic rst,
	pivot_bus_if.collector bus,
	output chol_num_pkg::root_mat_t l_matrix
);
	import chol_num_pkg::*;

	root_mat_t l_q; // Entries of L gathered column by column

	always_ff @(posedge i) begin
		if (rst || bus.load) begin
			l_q <= '0; // Upper triangle is never written and stays zero
		end else begin
			if (bus.root_valid)
				l_q[bus.col][bus.col] <= bus.root;
			if (bus.update_go) begin // Quotients are stable while the update runs
				for (int r = 0; r < `CHOL_N; r++) begin
					if (r > bus.col)
						l_q[r][bus.col] <= bus.quot[r];
				end
			end
		end
	end

	assign l_matrix = l_q; // Holds until the next load

endmodule

// File: logic/factor_sequencer.sv
/* Column sequencer */

`include "chol_settings.svh"

module factor_sequencer (
	input logic i,
	input logic rst,
	input logic start,
	output logic busy,
	output logic done,
	output logic error,
	output chol_num_pkg::elem_t radicand,
	output logic root_go,
	input chol_num_pkg::root_t root_result,
	input logic root_done,
	pivot_bus_if.seq bus
);
	import chol_num_pkg::*;
	import chol_ctrl_pkg::*;

	localparam col_idx_t LAST = col_idx_t'(`CHOL_N - 1); // Last column has no rows below it

	seq_state_t state;
	col_idx_t col;
	logic load_q; // Load pulse, one cycle after start
	logic pend; // Root unit is working on the current pivot
	elem_t pivot;
	logic issue; // Pivot is settled and not yet sent
	logic [`CHOL_N-1:0] lower_rows; // Lanes that divide in this column
	logic quots_ready;

	assign pivot = bus.diag[col]; // Diagonal of lane col after all earlier updates
	assign issue = (state == ROOT) && !pend && !load_q; // Lanes hold A one cycle after load
	assign radicand = pivot;
	assign root_go = issue && (pivot != '0);

	always_comb begin
		for (int r = 0; r < `CHOL_N; r++) begin
			lower_rows[r] = r > col;
		end
	end

	// Rows at or above the pivot do not divide, so their valid bits do not count
	assign quots_ready = &(bus.quot_valid | ~lower_rows);

	assign busy = state inside {ROOT, DIVIDE, UPDATE};
	assign done = state == FINISH;
	assign error = state == FAULT;

	assign bus.col = col;
	assign bus.load = load_q;
	assign bus.root = root_result; // Root unit holds its result until the next go
	assign bus.root_valid = (state == ROOT) && root_done;
	assign bus.update_go = state == UPDATE;

	always_ff @(posedge i) begin
		if (rst) begin
			state <= IDLE;
			col <= '0;
			load_q <= 1'b0;
			pend <= 1'b0;
		end else begin
			load_q <= 1'b0;
			if (!busy && start) begin // Also taken in the done or error cycle
				state <= ROOT;
				col <= '0;
				load_q <= 1'b1;
				pend <= 1'b0;
			end else begin
				case (state)
					ROOT: begin
						if (root_done) begin
							pend <= 1'b0;
							state <= (col == LAST) ? FINISH : DIVIDE; // Last column needs no division
						end else if (issue) begin
							if (pivot == '0)
								state <= FAULT; // Matrix is not positive definite
							else
								pend <= 1'b1;
						end
					end
					DIVIDE: begin
						if (quots_ready)
							state <= UPDATE;
					end
					UPDATE: begin
						col <= col + 1'b1; // Updated diagonal of the next lane is visible now
						state <= ROOT;
					end
					FINISH, FAULT: state <= IDLE;
					default: state <= IDLE;
				endcase
			end
		end
	end

	// A second pivot must not reach the root unit while it is still iterating
	a_go_spacing: assert property (@(posedge i) disable iff (rst)
		root_go |=> !root_go [*14]);

endmodule

// File: logic/cholesky_top.sv
/* Cholesky factor unit */

`include "chol_settings.svh"

module cholesky_top (
	input logic i,
	input logic rst,
	input logic start,
	input chol_num_pkg::elem_mat_t a_matrix,
	output logic busy,
	output logic done,
	output logic error,
	output chol_num_pkg::root_mat_t l_matrix
);
	import chol_num_pkg::*;

	elem_t radicand; // Pivot handed to the root unit
	logic root_go;
	root_t root_result;
	logic root_done;

	pivot_bus_if bus ();

	factor_sequencer u_seq (
		.i (i),
		.rst (rst),
		.start (start),
		.busy (busy),
		.done (done),
		.error (error),
		.radicand (radicand),
		.root_go (root_go),
		.root_result (root_result),
		.root_done (root_done),
		.bus (bus.seq)
	);

	isqrt_unit u_root (
		.i (i),
		.rst (rst),
		.radicand (radicand),
		.go (root_go),
		.result (root_result),
		.done (root_done)
	);

	// One lane per matrix row
	generate
		for (genvar g = 0; g < `CHOL_N; g++) begin : g_lane
			row_lane #(
				.ROW (g)
			) u_lane (
				.i (i),
				.rst (rst),
				.a_row (a_matrix[g]),
				.bus (bus.lane)
			);
		end
	endgenerate

	factor_collector u_coll (
		.i (i),
		.rst (rst),
		.bus (bus.collector),
		.l_matrix (l_matrix)
	);

endmodule

// File: test/clock_gen.sv
/* Testbench clock and reset */

module clock_gen (
	output logic i,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		i = 1'b0;
		forever #20 i = ~i; // 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge i); // Reset held for five rising edges
		rst <= 1'b0;
	end

endmodule

// File: test/cholesky_tb.sv
/* Cholesky factor testbench */

`include "chol_settings.svh"

module cholesky_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import chol_num_pkg::*;

	localparam int N = `CHOL_N;
	localparam int TAB_N = 4; // Table matrices are 4x4, the leading NxN block is used
	localparam int NUM_TAB = 8;
	localparam int NUM_RAND = 6;
	localparam int NUM_MATS = NUM_TAB + NUM_RAND + 1; // One extra run for the ignored start
	localparam int TIMEOUT_CYCLES = 200 * NUM_MATS + 100;

	typedef enum int {
		MODE_L, // Value is L, A is L times its transpose
		MODE_DIAG, // Value diagonal is A itself, L is its integer root
		MODE_BAD // Value is L with a zero first pivot, error expected
	} case_mode_t;

	logic i;
	logic rst;
	logic start;
	elem_mat_t a_matrix;
	logic busy;
	logic done;
	logic error;
	root_mat_t l_matrix;

	int cur_l [N][N]; // Source values of the current case
	int a_val [N][N]; // Matrix handed to the DUT
	int exp_l [N][N]; // Expected factor
	bit exp_err;
	int errors = 0;
	int cycles = 0;
	logic [31:0] lcg_state = 32'h813212f9;

	case_mode_t tab_mode [NUM_TAB] = '{MODE_L, MODE_L, MODE_L, MODE_L, MODE_L,
		MODE_DIAG, MODE_DIAG, MODE_BAD};

	int tab_val [NUM_TAB][TAB_N][TAB_N] = '{
		'{'{1, 0, 0, 0}, '{0, 1, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 1}}, // Identity
		'{'{2, 0, 0, 0}, '{1, 3, 0, 0}, '{4, 5, 6, 0}, '{7, 8, 9, 10}},
		'{'{10, 0, 0, 0}, '{0, 1, 0, 0}, '{3, 0, 7, 0}, '{0, 2, 0, 5}},
		'{'{100, 0, 0, 0}, '{60, 100, 0, 0}, '{60, 60, 100, 0}, '{60, 60, 60, 100}},
		'{'{1, 0, 0, 0}, '{1, 1, 0, 0}, '{1, 1, 1, 0}, '{1, 1, 1, 1}},
		'{'{10, 0, 0, 0}, '{0, 26, 0, 0}, '{0, 0, 1000000, 0}, '{0, 0, 0, 134217727}},
		'{'{2, 0, 0, 0}, '{0, 3, 0, 0}, '{0, 0, 48, 0}, '{0, 0, 0, 65535}},
		'{'{0, 0, 0, 0}, '{1, 2, 0, 0}, '{3, 1, 4, 0}, '{2, 2, 1, 3}} // Zero pivot
	};

	clock_gen u_clk (
		.i (i),
		.rst (rst)
	);

	cholesky_top dut (
		.i (i),
		.rst (rst),
		.start (start),
		.a_matrix (a_matrix),
		.busy (busy),
		.done (done),
		.error (error),
		.l_matrix (l_matrix)
	);

	// Run limit covers every matrix at its worst latency plus the reset
	always @(posedge i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: no result after %0d clock cycles", cycles);
			$display("Test failures found");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] time %0d ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "Stopped at the first failed check");
	endtask

	function automatic int isqrt_ref(input int x);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= x) // Largest r with r*r not above x
			r++;
		return r;
	endfunction

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:16]) % n; // Upper bits have the longer period
	endfunction

	task automatic load_table_entry(input int t);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				if (r < TAB_N && c < TAB_N)
					cur_l[r][c] = tab_val[t][r][c];
				else
					cur_l[r][c] = (r == c) ? 1 : 0; // Rows past the table extend as identity
			end
		end
	endtask

	task automatic load_random_entry();
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				if (c < r)
					cur_l[r][c] = rand_below(61);
				else if (c == r)
					cur_l[r][c] = 1 + rand_below(100); // Non-zero diagonal keeps A definite
				else
					cur_l[r][c] = 0;
			end
		end
	endtask

	task automatic prepare_case(input case_mode_t mode);
		int s;
		exp_err = (mode == MODE_BAD);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				exp_l[r][c] = 0;
				a_val[r][c] = 0;
			end
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				if (mode == MODE_DIAG) begin
					if (r == c) begin
						a_val[r][r] = cur_l[r][r];
						exp_l[r][r] = isqrt_ref(cur_l[r][r]); // Floor of the root
					end
				end else begin
					s = 0;
					for (int k = 0; k <= r && k <= c; k++)
						s += cur_l[r][k] * cur_l[c][k]; // A = L * L^T
					a_val[r][c] = s;
					if (c <= r)
						exp_l[r][c] = cur_l[r][c];
				end
			end
		end
	endtask

	task automatic apply_start();
		@(posedge i);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				a_matrix[r][c] <= elem_t'(a_val[r][c]);
		end
		start <= 1'b1;
		@(posedge i);
		start <= 1'b0; // Single cycle pulse
		@(negedge i);
		assert (busy) else report_error("busy did not rise the cycle after start");
	endtask

	task automatic wait_result();
		while (!(done || error)) // Bounded by the cycle limit
			@(negedge i);
	endtask

	task automatic check_result();
		if (exp_err) begin
			assert (error && !done) else report_error("zero pivot did not give error alone");
			assert (!busy) else report_error("busy still high with error");
			@(negedge i);
			assert (!busy && !error) else report_error("busy or error high after the fault");
		end else begin
			assert (done && !error) else report_error("expected done without error");
			assert (!busy) else report_error("busy still high with done");
			for (int r = 0; r < N; r++) begin
				for (int c = 0; c < N; c++) begin
					if (c > r) begin
						assert (l_matrix[r][c] == '0) else
							report_error($sformatf("L[%0d][%0d] above the diagonal not zero",
								r, c));
					end else begin
						assert (l_matrix[r][c] == root_t'(exp_l[r][c])) else
							report_error($sformatf("L[%0d][%0d] is %0d, expected %0d",
								r, c, l_matrix[r][c], exp_l[r][c]));
					end
				end
			end
		end
	endtask

	task automatic run_case();
		apply_start();
		wait_result();
		check_result();
	endtask

	initial begin
		start = 1'b0;
		a_matrix = '0;
		@(negedge i);
		while (rst)
			@(negedge i);
		assert (!busy && !done && !error) else report_error("control outputs high after reset");
		assert (l_matrix == '0) else report_error("l_matrix not zero after reset");

		for (int t = 0; t < NUM_TAB; t++) begin
			load_table_entry(t);
			prepare_case(tab_mode[t]);
			run_case();
		end

		// Second start while busy carries another matrix and must be dropped
		load_table_entry(1);
		prepare_case(MODE_L);
		apply_start();
		@(posedge i);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				a_matrix[r][c] <= elem_t'(r * 7 + c + 1);
		end
		start <= 1'b1;
		@(posedge i);
		start <= 1'b0;
		wait_result();
		check_result();

		for (int n = 0; n < NUM_RAND; n++) begin
			load_random_entry();
			prepare_case(MODE_L);
			run_case();
		end

		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: cholesky.f
+incdir+logic
logic/chol_num_pkg.sv
logic/chol_ctrl_pkg.sv
logic/pivot_bus_if.sv
logic/isqrt_unit.sv
logic/row_lane.sv
logic/factor_collector.sv
logic/factor_sequencer.sv
logic/cholesky_top.sv
test/clock_gen.sv
test/cholesky_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f cholesky.f \
	--top-module cholesky_tb -Mdir obj_dir -o cholesky_sim \
	&& ./obj_dir/cholesky_sim > sim.log 2>&1 \
	|| echo "Simulation build or run ended with an error" >> sim.log

cat sim.log
test -s sim.log && ! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
